//--- list.f
+incdir+bench
common/tile_pkg.sv
common/raster_if.sv
source/tile_lane.sv
source/square_raster.sv
sequencer/frame_timer.sv
sequencer/plot_sequencer.sv
source/tile_top.sv
bench/tile_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tile_tb
LIST  = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tile_model.svh
`ifndef TILE_MODEL_SVH
`define TILE_MODEL_SVH

// replayed column state
lfsr_t                model_lfsr;
logic [NUM_SLOTS-1:0] model_occ;

// expected pixel stream over all frames of one run
pixel_x_t exp_x[$];
pixel_y_t exp_y[$];
colour_t  exp_c[$];

// index of each frame's first draw pixel and first erase pixel
int frame_start[$];
int erase_start[$];

task automatic reset_model;
	model_lfsr = LFSR_SEED;
	model_occ  = '0;
	exp_x.delete();
	exp_y.delete();
	exp_c.delete();
	frame_start.delete();
	erase_start.delete();
endtask

// rows top to bottom and columns left to right
task automatic add_square(input int slot, input colour_t colour);
	for (int dy = 0; dy < SQUARE_SIZE; dy++) begin
		for (int dx = 0; dx < SQUARE_SIZE; dx++) begin
			exp_x.push_back(pixel_x_t'(ORIGIN_X + dx));
			exp_y.push_back(pixel_y_t'(ORIGIN_Y + slot * SLOT_PITCH + dy));
			exp_c.push_back(colour);
		end
	end
endtask

task automatic add_frame(input colour_t colour);
	// column moves down and the new top slot takes lfsr bit 4
	for (int i = NUM_SLOTS - 1; i > 0; i--)
		model_occ[i] = model_occ[i-1];
	model_occ[0] = model_lfsr[4];
	model_lfsr   = {model_lfsr[3:0], model_lfsr[4] ^ model_lfsr[1]};
	frame_start.push_back(exp_x.size());
	for (int slot = 0; slot < NUM_SLOTS; slot++) begin
		if (model_occ[slot])
			add_square(slot, colour);
	end
	erase_start.push_back(exp_x.size());
	for (int slot = 0; slot < NUM_SLOTS; slot++)
		add_square(slot, ERASE_COLOUR);
endtask

task automatic compare_pixel(input int index,
	input pixel_x_t got_px, input pixel_y_t got_py, input colour_t got_pc,
	input pixel_x_t want_px, input pixel_y_t want_py, input colour_t want_pc);
	if (got_px !== want_px) begin
		value_errors++;
		$display("FAIL o_x pixel %0d: got 0x%h, expected 0x%h", index, got_px, want_px);
	end
	if (got_py !== want_py) begin
		value_errors++;
		$display("FAIL o_y pixel %0d: got 0x%h, expected 0x%h", index, got_py, want_py);
	end
	if (got_pc !== want_pc) begin
		value_errors++;
		$display("FAIL o_colour pixel %0d: got 0x%h, expected 0x%h", index, got_pc, want_pc);
	end
endtask

task automatic compare_count(input string name, input int got, input int want);
	if (got != want) begin
		value_errors++;
		$display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
	end
endtask

// received stream against the model, plus draw counts and hold gaps per frame
task automatic check_stream(input string name);
	int limit;
	int drawn;
	int gap;
	limit = exp_x.size();
	if (got_x.size() < limit)
		limit = got_x.size();
	for (int i = 0; i < limit; i++)
		compare_pixel(i, got_x[i], got_y[i], got_c[i], exp_x[i], exp_y[i], exp_c[i]);
	for (int f = 0; f < frame_start.size(); f++) begin
		drawn = 0;
		for (int i = frame_start[f]; i < erase_start[f] && i < limit; i++) begin
			if (got_c[i] != ERASE_COLOUR)
				drawn++;
		end
		compare_count($sformatf("%s frame %0d draw pixels", name, f), drawn,
			erase_start[f] - frame_start[f]);
		if (erase_start[f] > frame_start[f] && erase_start[f] < limit) begin
			gap = got_cycle[erase_start[f]] - got_cycle[erase_start[f] - 1];
			if (gap <= FRAME_TICKS) begin
				other_errors++;
				$display("%s frame %0d: erase started %0d cycles after the last draw pixel",
					name, f, gap);
			end
		end
	end
endtask

`endif

//--- bench/tile_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tile_tb;
	import tile_pkg::*;

	localparam int NUM_SLOTS   = 8;
	localparam int FRAME_TICKS = 10;
	localparam int CREDITS     = 4;
	localparam int MAX_DELAY   = 6;

	// 1 + 6 + 4 + 6 frames over all tests
	localparam int TOTAL_FRAMES   = 17;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (256 * MAX_DELAY + FRAME_TICKS) * 2;

	logic     clock;
	logic     rst_n;
	logic     i_go;
	colour_t  i_colour;
	logic     i_credit;
	logic     o_plot;
	pixel_x_t o_x;
	pixel_y_t o_y;
	colour_t  o_colour;

	// pixels seen by the consumer, with the cycle they arrived in
	pixel_x_t got_x[$];
	pixel_y_t got_y[$];
	colour_t  got_c[$];
	int       got_cycle[$];

	int cycle;
	int value_errors;
	int other_errors;
	int returns_sent;
	int returns_seen;
	int wait_left;
	int fixed_delay;
	bit random_delay;

	`include "tile_model.svh"

	tile_top #(
		.NUM_SLOTS  (NUM_SLOTS),
		.FRAME_TICKS(FRAME_TICKS),
		.CREDITS    (CREDITS)
	) uut (
		.clock   (clock),
		.rst_n   (rst_n),
		.i_go    (i_go),
		.i_colour(i_colour),
		.i_credit(i_credit),
		.o_plot  (o_plot),
		.o_x     (o_x),
		.o_y     (o_y),
		.o_colour(o_colour)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle > TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles, pixel stream did not finish", cycle);
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	// consumer samples at the falling edge where outputs are settled
	always @(negedge clock) begin
		if (rst_n) begin
			if (i_credit)
				returns_seen++;
			if (o_plot) begin
				got_x.push_back(o_x);
				got_y.push_back(o_y);
				got_c.push_back(o_colour);
				got_cycle.push_back(cycle);
			end
			if (got_x.size() - returns_seen > CREDITS) begin
				other_errors++;
				$display("more than %0d pixels outstanding at cycle %0d", CREDITS, cycle);
			end
		end
	end

	// one credit back per received pixel, after a delay
	always @(posedge clock) begin
		#1;
		i_credit = 1'b0;
		if (rst_n && returns_sent < got_x.size()) begin
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				i_credit     = 1'b1;
				returns_sent++;
				wait_left    = random_delay ? $urandom_range(MAX_DELAY, 0) : fixed_delay;
			end
		end
	end

	task automatic step_clock;
		@(posedge clock);
		#1;
	endtask

	task automatic apply_reset;
		step_clock();
		rst_n = 1'b0;
		i_go  = 1'b0;
		@(negedge clock);
		got_x.delete();
		got_y.delete();
		got_c.delete();
		got_cycle.delete();
		returns_sent = 0;
		returns_seen = 0;
		wait_left    = 0;
		repeat (4) step_clock();
		rst_n = 1'b1;
	endtask

	task automatic start_frames;
		i_go = 1'b1;
		step_clock();
		i_go = 1'b0;
	endtask

	task automatic wait_for_pixels(input int count);
		while (got_x.size() < count)
			step_clock();
	endtask

	task automatic idle_stays_quiet;
		apply_reset();
		i_colour = 3'b111;
		repeat (50) step_clock();
		compare_count("o_plot pulses with i_go low", got_x.size(), 0);
	endtask

	// seed gives an empty top slot, so only the erase shows up
	task automatic first_frame_erase;
		int black;
		fixed_delay  = 0;
		random_delay = 1'b0;
		apply_reset();
		reset_model();
		add_frame(3'b101);
		i_colour = 3'b101;
		start_frames();
		wait_for_pixels(exp_x.size());
		check_stream("first frame");
		black = 0;
		for (int i = 0; i < got_c.size() && i < NUM_SLOTS * 16; i++) begin
			if (got_c[i] == ERASE_COLOUR)
				black++;
		end
		compare_count("first frame black pixels", black, NUM_SLOTS * 16);
	endtask

	task automatic run_six_frames(input string name, input bit slow);
		fixed_delay  = 2;
		random_delay = slow;
		apply_reset();
		reset_model();
		repeat (6) add_frame(3'b110);
		i_colour = 3'b110;
		start_frames();
		wait_for_pixels(exp_x.size());
		check_stream(name);
	endtask

	// switch colour once the second frame has begun drawing
	task automatic colour_change_next_frame;
		fixed_delay  = 1;
		random_delay = 1'b0;
		apply_reset();
		reset_model();
		add_frame(3'b010);
		add_frame(3'b010);
		add_frame(3'b100);
		add_frame(3'b100);
		i_colour = 3'b010;
		start_frames();
		wait_for_pixels(frame_start[1] + 1);
		i_colour = 3'b100;
		wait_for_pixels(exp_x.size());
		check_stream("colour change");
	endtask

	initial begin
		rst_n        = 1'b0;
		i_go         = 1'b0;
		i_colour     = '0;
		i_credit     = 1'b0;
		cycle        = 0;
		value_errors = 0;
		other_errors = 0;
		returns_sent = 0;
		returns_seen = 0;
		wait_left    = 0;
		fixed_delay  = 0;
		random_delay = 1'b0;
		void'($urandom(32'h944e_8855));

		idle_stays_quiet();
		first_frame_erase();
		run_six_frames("fixed credits", 1'b0);
		colour_change_next_frame();
		run_six_frames("back pressure", 1'b1);

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/tile_top.sv
`timescale 1ns/1ns
`default_nettype none

module tile_top #(
	parameter int NUM_SLOTS   = 8,
	parameter int FRAME_TICKS = 10,
	parameter int CREDITS     = 4
) (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    i_go,
	input  wire tile_pkg::colour_t i_colour,
	input  wire                    i_credit,
	output logic                   o_plot,
	output tile_pkg::pixel_x_t     o_x,
	output tile_pkg::pixel_y_t     o_y,
	output tile_pkg::colour_t      o_colour
);
	logic [NUM_SLOTS-1:0] occupied;
	logic                 shift;

	raster_if raster_link ();

	tile_lane #(
		.NUM_SLOTS(NUM_SLOTS)
	) lane (
		.clock     (clock),
		.rst_n     (rst_n),
		.i_shift   (shift),
		.o_occupied(occupied)
	);

	square_raster raster (
		.clock (clock),
		.rst_n (rst_n),
		.raster(raster_link.target)
	);

	plot_sequencer #(
		.NUM_SLOTS  (NUM_SLOTS),
		.FRAME_TICKS(FRAME_TICKS),
		.CREDITS    (CREDITS)
	) sequencer (
		.clock     (clock),
		.rst_n     (rst_n),
		.i_go      (i_go),
		.i_colour  (i_colour),
		.i_credit  (i_credit),
		.i_occupied(occupied),
		.o_shift   (shift),
		.raster    (raster_link.initiator),
		.o_plot    (o_plot),
		.o_x       (o_x),
		.o_y       (o_y),
		.o_colour  (o_colour)
	);

endmodule

`default_nettype wire

//--- sequencer/plot_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module plot_sequencer #(
	parameter int NUM_SLOTS   = 8,
	parameter int FRAME_TICKS = 10,
	parameter int CREDITS     = 4
) (
	input  wire                      clock,
	input  wire                      rst_n,
	input  wire                      i_go,
	input  wire tile_pkg::colour_t   i_colour,
	input  wire                      i_credit,
	input  wire [NUM_SLOTS-1:0]      i_occupied,
	output logic                     o_shift,
	raster_if.initiator              raster,
	output logic                     o_plot,
	output tile_pkg::pixel_x_t       o_x,
	output tile_pkg::pixel_y_t       o_y,
	output tile_pkg::colour_t        o_colour
);
	import tile_pkg::*;

	localparam int SW = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	localparam int CW = $clog2(CREDITS + 1);

	seq_state_e    state;
	seq_state_e    next_state;
	logic [SW-1:0] slot;
	logic [CW-1:0] credits;
	colour_t       colour_q;
	logic          has_credit;
	logic          issuing;
	logic          slot_done;
	logic          last_slot;
	logic          hold_start;
	logic          hold_done;

	assign has_credit = (credits != '0);
	assign last_slot  = (slot == SW'(NUM_SLOTS - 1));

	// pixel request and end of the current slot
	always_comb begin
		issuing   = 1'b0;
		slot_done = 1'b0;
		case (state)
			DRAW: begin
				// empty slots cost one cycle each
				issuing   = i_occupied[slot];
				slot_done = !i_occupied[slot] || (has_credit && raster.last);
			end
			ERASE: begin
				issuing   = 1'b1;
				slot_done = has_credit && raster.last;
			end
			default: issuing = 1'b0;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (i_go) next_state = SHIFT;
			SHIFT: next_state = DRAW;
			DRAW: if (slot_done && last_slot) next_state = HOLD;
			HOLD: if (hold_done) next_state = ERASE;
			ERASE: if (slot_done && last_slot) next_state = SHIFT;
			default: next_state = IDLE;
		endcase
	end

	// timer is armed in the last draw cycle so HOLD is exactly FRAME_TICKS long
	assign hold_start = (state == DRAW) && (next_state == HOLD);

	frame_timer #(
		.FRAME_TICKS(FRAME_TICKS)
	) hold_timer (
		.clock    (clock),
		.rst_n    (rst_n),
		.i_start  (hold_start),
		.o_expired(hold_done)
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			slot  <= '0;
		end else begin
			state <= next_state;
			if (slot_done)
				slot <= last_slot ? '0 : slot + 1'b1;
		end
	end

	// colour for the whole frame, taken while the column shifts
	always_ff @(posedge clock) begin
		if (state == SHIFT)
			colour_q <= i_colour;
	end

	// a spend and a return in the same cycle cancel out
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			credits <= CW'(CREDITS);
		else if (o_plot && !i_credit)
			credits <= credits - 1'b1;
		else if (i_credit && !o_plot)
			credits <= credits + 1'b1;
	end

	assign o_shift     = (state == SHIFT);
	assign o_plot      = issuing && has_credit;
	assign raster.step = o_plot;

	// slot origin plus the raster offset
	assign o_x = pixel_x_t'(ORIGIN_X) + pixel_x_t'(raster.dx);
	assign o_y = pixel_y_t'(ORIGIN_Y) + pixel_y_t'(slot) * pixel_y_t'(SLOT_PITCH) +
		pixel_y_t'(raster.dy);
	assign o_colour = (state == ERASE) ? ERASE_COLOUR : colour_q;

	// consumer must not return more credits than pixels it received
	a_credit_bound: assert property (
		@(posedge clock) disable iff (!rst_n)
		credits <= CW'(CREDITS)
	);

	a_plot_has_credit: assert property (
		@(posedge clock) disable iff (!rst_n)
		o_plot |-> credits > '0
	);

	// shift is a single cycle and the draw phase follows it
	a_shift_state: assert property (
		@(posedge clock) disable iff (!rst_n)
		o_shift |-> (state == SHIFT) ##1 (state == DRAW)
	);

endmodule

`default_nettype wire

//--- sequencer/frame_timer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_timer #(
	parameter int FRAME_TICKS = 10
) (
	input  wire  clock,
	input  wire  rst_n,
	input  wire  i_start,
	output logic o_expired
);
	localparam int W = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

	logic [W-1:0] count;
	logic         running;

	// loaded in the cycle before the hold, counts FRAME_TICKS-1 down to 0
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			count   <= '0;
			running <= 1'b0;
		end else if (i_start) begin
			count   <= W'(FRAME_TICKS - 1);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign o_expired = running && (count == '0);

endmodule

`default_nettype wire

//--- source/square_raster.sv
`timescale 1ns/1ns
`default_nettype none

module square_raster (
	input wire        clock,
	input wire        rst_n,
	raster_if.target  raster
);
	import tile_pkg::*;

	// low pair is dx and high pair is dy
	logic [3:0] count;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (raster.step) begin
			// wraps to (0, 0) after the final pixel
			count <= count + 1'b1;
		end
	end

	assign raster.dx = count[1:0];
	assign raster.dy = count[3:2];

	assign raster.last = (raster.dx == offset_t'(SQUARE_SIZE - 1)) &&
		(raster.dy == offset_t'(SQUARE_SIZE - 1));

	// the sequencer shares this reset and must stay quiet while it is held
	a_no_step_in_reset: assert property (
		@(posedge clock)
		!rst_n |-> !raster.step
	);

endmodule

`default_nettype wire

//--- source/tile_lane.sv
`timescale 1ns/1ns
`default_nettype none

module tile_lane #(
	parameter int NUM_SLOTS = 8
) (
	input  wire                  clock,
	input  wire                  rst_n,
	input  wire                  i_shift,
	output logic [NUM_SLOTS-1:0] o_occupied
);
	import tile_pkg::*;

	lfsr_t lfsr;
	logic  feedback;

	// taps at bits 4 and 1
	assign feedback = lfsr[4] ^ lfsr[1];

	// the lfsr only steps with the column so each frame sees one value
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= LFSR_SEED;
		end else if (i_shift) begin
			lfsr <= {lfsr[3:0], feedback};
		end
	end

	// slot 0 is the top of the column and tiles move towards higher slots
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			o_occupied <= '0;
		end else if (i_shift) begin
			o_occupied[0] <= lfsr[4];
			for (int i = 1; i < NUM_SLOTS; i++) begin
				o_occupied[i] <= o_occupied[i-1];
			end
		end
	end

endmodule

`default_nettype wire

//--- common/raster_if.sv
`timescale 1ns/1ns
`default_nettype none

interface raster_if;
	import tile_pkg::*;

	// one pixel issued this cycle
	logic    step;

	// current offset inside the square
	offset_t dx;
	offset_t dy;

	// offset is (3, 3)
	logic    last;

	modport initiator (
		output step,
		input  dx,
		input  dy,
		input  last
	);

	modport target (
		input  step,
		output dx,
		output dy,
		output last
	);

endinterface

`default_nettype wire

//--- common/tile_pkg.sv
`default_nettype none

package tile_pkg;

	// screen coordinate and colour types
	typedef logic [7:0] pixel_x_t;
	typedef logic [6:0] pixel_y_t;

	// one bit per channel, r g b
	typedef logic [2:0] colour_t;

	// offset of a pixel inside one square
	typedef logic [1:0] offset_t;

	typedef logic [4:0] lfsr_t;

	// nonzero seed, the all-zero state locks the lfsr
	localparam lfsr_t LFSR_SEED = 5'h0F;

	// tile geometry in pixels
	localparam int SQUARE_SIZE = 4;
	localparam int ORIGIN_X    = 1;
	localparam int ORIGIN_Y    = 1;

	// one pixel gap between neighbouring slots
	localparam int SLOT_PITCH  = 5;

	localparam colour_t ERASE_COLOUR = 3'b000;

	// frame sequencer states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		SHIFT = 3'd1,
		DRAW  = 3'd2,
		HOLD  = 3'd3,
		ERASE = 3'd4
	} seq_state_e;

endpackage

`default_nettype wire
